//--- usb_tx.f
rtl/usb_proto_pkg.sv
rtl/usb_tx_cfg_pkg.sv
rtl/usb_tx_fifo.sv
rtl/usb_tx_crc16.sv
rtl/usb_tx_encoder.sv
rtl/usb_tx_controller.sv
rtl/usb_tx.sv
testbench/tb_usb_tx.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary -j 0
TOP ?= tb_usb_tx
FILELIST ?= usb_tx.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || (echo "test FAILED, no result in log"; exit 1)
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_usb_tx.sv
// USB transmitter testbench
`timescale 1ns/1ps
`default_nettype none

module tb_usb_tx;

	localparam int DEPTH = usb_tx_cfg_pkg::FIFO_DEPTH;
	localparam int DIV = usb_tx_cfg_pkg::BIT_DIV;
	localparam int N_RANDOM = 10;
	localparam int N_FF = 4;
	localparam int N_PACKETS = 3 + N_RANDOM + N_FF + 2;
	// SYNC, PID, full payload and two CRC bytes
	localparam int MAX_PKT_BYTES = DEPTH + 4;
	localparam int WATCHDOG_CLKS = N_PACKETS * (MAX_PKT_BYTES * 8 * DIV * 2 + 100) + 50;

	logic clk;
	logic n_rst;
	logic [7:0] in_data;
	logic in_valid;
	logic in_ready;
	usb_proto_pkg::pid_t send_pid;
	logic [usb_tx_cfg_pkg::CNT_W-1:0] send_len;
	logic send_valid;
	logic send_ready;
	logic dp;
	logic dm;
	logic busy;

	logic [31:0] lfsr = 32'hadcb_a5ac;
	logic [7:0] fifo_model[$];
	logic [7:0] exp_q[$];
	int exp_len_q[$];
	int pkts_sent = 0;
	int eop_count = 0;

	usb_tx usb_tx_inst (
		.clk(clk), .n_rst(n_rst),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.send_pid(send_pid), .send_len(send_len),
		.send_valid(send_valid), .send_ready(send_ready),
		.dp(dp), .dm(dm), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] crc16_byte(input logic [15:0] c, input logic [7:0] b);
		logic fb;
		for (int i = 0; i < 8; i++) begin
			fb = c[0] ^ b[i];
			c = c >> 1;
			if (fb)
				c = c ^ usb_proto_pkg::CRC16_POLY_REV;
		end
		return c;
	endfunction

	function automatic bit is_data(input usb_proto_pkg::pid_t p);
		return (p == usb_proto_pkg::PID_DATA0) || (p == usb_proto_pkg::PID_DATA1);
	endfunction

	task automatic write_byte(input logic [7:0] b);
		logic took;
		in_data = b;
		in_valid = 1'b1;
		do begin
			@(negedge clk);
			took = in_ready;
			@(posedge clk);
			#2;
		end while (!took);
		in_valid = 1'b0;
		fifo_model.push_back(b);
	endtask

	// Mostly 0xFF when ff_rich to force long runs of ones
	task automatic write_payload(input int n, input bit ff_rich);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			if (ff_rich && random_bits(2) != 0)
				b = 8'hff;
			else
				b = 8'(random_bits(8));
			write_byte(b);
		end
	endtask

	task automatic send_packet(input usb_proto_pkg::pid_t pid, input int len);
		logic took;
		logic ready_exp;
		int eff;
		logic [15:0] crc;
		logic [7:0] b;
		logic [3:0] code;
		eff = is_data(pid) ? len : 0;
		send_pid = pid;
		send_len = usb_tx_cfg_pkg::CNT_W'(len);
		send_valid = 1'b1;
		do begin
			@(negedge clk);
			took = send_ready;
			ready_exp = !busy && (fifo_model.size() >= eff);
			check_value("send_ready", 32'(send_ready), 32'(ready_exp));
			@(posedge clk);
			#2;
		end while (!took);
		send_valid = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
		code = pid;
		exp_q.push_back(usb_proto_pkg::SYNC_BYTE);
		exp_q.push_back({~code, code});
		if (is_data(pid)) begin
			crc = usb_proto_pkg::CRC16_INIT;
			for (int i = 0; i < eff; i++) begin
				b = fifo_model.pop_front();
				exp_q.push_back(b);
				crc = crc16_byte(crc, b);
			end
			crc = ~crc;
			exp_q.push_back(crc[7:0]);
			exp_q.push_back(crc[15:8]);
		end
		exp_len_q.push_back(is_data(pid) ? eff + 4 : 2);
		pkts_sent++;
	endtask

	task automatic wait_idle();
		do
			@(negedge clk);
		while (busy);
		check_value("eop count", 32'(eop_count), 32'(pkts_sent));
		@(posedge clk);
		#2;
	endtask

	// The line must hold for a whole bit window
	task automatic sample_bit(output logic [1:0] lvl);
		lvl = {dp, dm};
		repeat (DIV - 1) begin
			@(negedge clk);
			check_value("line held for a bit", 32'({dp, dm}), 32'(lvl));
		end
		@(negedge clk);
	endtask

	initial begin : line_decoder
		logic [1:0] lvl;
		logic prev_dp;
		logic bitv;
		logic [7:0] shreg;
		int nbits;
		int ones;
		int nbytes;
		bit done;
		wait (n_rst === 1'b1);
		forever begin
			@(negedge clk);
			if ({dp, dm} != 2'b10) begin
				prev_dp = 1'b1;
				shreg = '0;
				nbits = 0;
				ones = 0;
				nbytes = 0;
				done = 0;
				while (!done) begin
					sample_bit(lvl);
					if (lvl == 2'b00) begin
						sample_bit(lvl);
						check_value("eop second se0", 32'(lvl), 32'd0);
						sample_bit(lvl);
						check_value("eop closing j", 32'(lvl), 32'd2);
						check_value("bits left at eop", 32'(nbits), 32'd0);
						if (exp_len_q.size() == 0)
							abort_run("End of packet seen with no packet requested");
						check_value("packet bytes", 32'(nbytes), 32'(exp_len_q.pop_front()));
						eop_count++;
						done = 1;
					end else if (lvl == 2'b11) begin
						abort_run("Both line wires high, SE1 is never valid");
					end else begin
						// NRZI where no change means a one
						bitv = (lvl[1] == prev_dp);
						prev_dp = lvl[1];
						if (ones == usb_proto_pkg::STUFF_RUN) begin
							if (bitv)
								abort_run("Stuffing error, seven ones in a row on the line");
							ones = 0;
						end else begin
							ones = bitv ? ones + 1 : 0;
							shreg = {bitv, shreg[7:1]};
							nbits++;
							if (nbits == 8) begin
								if (exp_q.size() == 0)
									abort_run("Byte decoded from the line with none expected");
								check_value("line byte", 32'(shreg), 32'(exp_q.pop_front()));
								nbits = 0;
								nbytes++;
							end
						end
					end
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge clk);
		abort_run("Watchdog timeout, the transmitter did not finish in time");
	end

	initial begin : stimulus
		int len;
		usb_proto_pkg::pid_t pid;
		in_data = '0;
		in_valid = 1'b0;
		send_pid = usb_proto_pkg::PID_ACK;
		send_len = '0;
		send_valid = 1'b0;
		n_rst = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		n_rst = 1'b1;
		check_value("dp", 32'(dp), 32'd1);
		check_value("dm", 32'(dm), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		check_value("in_ready", 32'(in_ready), 32'd1);

		// Handshakes ignore send_len
		send_packet(usb_proto_pkg::PID_ACK, int'(random_bits(5) % 17));
		wait_idle();
		send_packet(usb_proto_pkg::PID_NAK, int'(random_bits(5) % 17));
		wait_idle();
		send_packet(usb_proto_pkg::PID_STALL, int'(random_bits(5) % 17));
		wait_idle();

		for (int i = 0; i < N_RANDOM + N_FF; i++) begin
			len = (i < N_RANDOM) ? int'(random_bits(5) % 17) : DEPTH;
			pid = (random_bits(1) == 1) ? usb_proto_pkg::PID_DATA1 : usb_proto_pkg::PID_DATA0;
			write_payload(len, i >= N_RANDOM);
			send_packet(pid, len);
			wait_idle();
		end

		write_payload(DEPTH, 0);
		check_value("in_ready when full", 32'(in_ready), 32'd0);
		send_packet(usb_proto_pkg::PID_DATA0, DEPTH);
		// Part of the next payload arrives during the packet and the rest after it
		fork
			begin
				write_payload(5, 0);
				wait_idle();
				repeat (8) @(posedge clk);
				#2;
				write_payload(4, 0);
			end
			send_packet(usb_proto_pkg::PID_DATA1, 9);
		join
		wait_idle();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/usb_tx.sv
// USB full-speed packet transmitter
`timescale 1ns/1ps
`default_nettype none

module usb_tx (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic [7:0] in_data,
	input wire logic in_valid,
	output logic in_ready,
	input wire usb_proto_pkg::pid_t send_pid,
	input wire logic [usb_tx_cfg_pkg::CNT_W-1:0] send_len,
	input wire logic send_valid,
	output logic send_ready,
	output logic dp,
	output logic dm,
	output logic busy
);

	logic rd_en;
	logic [7:0] rd_data;
	logic [usb_tx_cfg_pkg::CNT_W-1:0] count;
	logic crc_clear;
	logic crc_enable;
	logic [15:0] crc;
	usb_tx_cfg_pkg::byte_sel_t byte_sel;
	usb_proto_pkg::pid_t pid_latched;
	logic byte_valid;
	logic byte_ready;
	logic eop_req;
	logic eop_done;

	usb_tx_fifo usb_tx_fifo_inst (
		.clk(clk), .n_rst(n_rst),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.rd_en(rd_en), .rd_data(rd_data), .count(count)
	);

	usb_tx_crc16 usb_tx_crc16_inst (
		.clk(clk), .n_rst(n_rst),
		.crc_clear(crc_clear), .crc_enable(crc_enable),
		.data(rd_data), .crc(crc)
	);

	usb_tx_encoder usb_tx_encoder_inst (
		.clk(clk), .n_rst(n_rst),
		.byte_sel(byte_sel), .pid(pid_latched), .rd_data(rd_data), .crc(crc),
		.byte_valid(byte_valid), .byte_ready(byte_ready),
		.eop_req(eop_req), .eop_done(eop_done),
		.dp(dp), .dm(dm)
	);

	usb_tx_controller usb_tx_controller_inst (
		.clk(clk), .n_rst(n_rst),
		.send_pid(send_pid), .send_len(send_len),
		.send_valid(send_valid), .send_ready(send_ready),
		.count(count), .rd_en(rd_en),
		.crc_clear(crc_clear), .crc_enable(crc_enable),
		.byte_sel(byte_sel), .pid_latched(pid_latched),
		.byte_valid(byte_valid), .byte_ready(byte_ready),
		.eop_req(eop_req), .eop_done(eop_done),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- rtl/usb_tx_controller.sv
// Packet sequencing controller
`timescale 1ns/1ps
`default_nettype none

module usb_tx_controller (
	input wire logic clk,
	input wire logic n_rst,
	input wire usb_proto_pkg::pid_t send_pid,
	input wire logic [usb_tx_cfg_pkg::CNT_W-1:0] send_len,
	input wire logic send_valid,
	output logic send_ready,
	input wire logic [usb_tx_cfg_pkg::CNT_W-1:0] count,
	output logic rd_en,
	output logic crc_clear,
	output logic crc_enable,
	output usb_tx_cfg_pkg::byte_sel_t byte_sel,
	output usb_proto_pkg::pid_t pid_latched,
	output logic byte_valid,
	input wire logic byte_ready,
	output logic eop_req,
	input wire logic eop_done,
	output logic busy
);

	usb_tx_cfg_pkg::tx_state_t state;
	usb_tx_cfg_pkg::tx_state_t next_state;
	logic [usb_tx_cfg_pkg::CNT_W-1:0] len_left;
	logic [usb_tx_cfg_pkg::CNT_W-1:0] eff_len;
	logic accept;

	function automatic logic is_data_pid(input usb_proto_pkg::pid_t p);
		return (p == usb_proto_pkg::PID_DATA0) || (p == usb_proto_pkg::PID_DATA1);
	endfunction

	// Handshakes carry no payload
	assign eff_len = is_data_pid(send_pid) ? send_len : '0;
	assign send_ready = (state == usb_tx_cfg_pkg::S_IDLE) && (count >= eff_len);
	assign accept = send_valid && send_ready;
	assign busy = (state != usb_tx_cfg_pkg::S_IDLE);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= usb_tx_cfg_pkg::S_IDLE;
			pid_latched <= usb_proto_pkg::PID_ACK;
			len_left <= '0;
		end else begin
			state <= next_state;
			if (accept) begin
				pid_latched <= send_pid;
				len_left <= eff_len;
			end else if (rd_en) begin
				len_left <= len_left - 1;
			end
		end
	end

	always_comb begin
		next_state = state;
		byte_sel = usb_tx_cfg_pkg::SEL_SYNC;
		byte_valid = 1'b0;
		rd_en = 1'b0;
		crc_clear = accept;
		eop_req = 1'b0;
		case (state)
			usb_tx_cfg_pkg::S_IDLE: begin
				if (accept)
					next_state = usb_tx_cfg_pkg::S_SYNC;
			end
			usb_tx_cfg_pkg::S_SYNC: begin
				byte_valid = 1'b1;
				if (byte_ready)
					next_state = usb_tx_cfg_pkg::S_PID;
			end
			usb_tx_cfg_pkg::S_PID: begin
				byte_sel = usb_tx_cfg_pkg::SEL_PID;
				byte_valid = 1'b1;
				if (byte_ready) begin
					if (!is_data_pid(pid_latched))
						next_state = usb_tx_cfg_pkg::S_EOP;
					else if (len_left == 0)
						next_state = usb_tx_cfg_pkg::S_CRC_WAIT;
					else
						next_state = usb_tx_cfg_pkg::S_DATA;
				end
			end
			usb_tx_cfg_pkg::S_DATA: begin
				byte_sel = usb_tx_cfg_pkg::SEL_DATA;
				byte_valid = 1'b1;
				if (byte_ready) begin
					rd_en = 1'b1;
					if (len_left == 1)
						next_state = usb_tx_cfg_pkg::S_CRC_WAIT;
				end
			end
			// Last payload byte folds into the CRC here
			usb_tx_cfg_pkg::S_CRC_WAIT: next_state = usb_tx_cfg_pkg::S_CRC_LO;
			usb_tx_cfg_pkg::S_CRC_LO: begin
				byte_sel = usb_tx_cfg_pkg::SEL_CRC_LO;
				byte_valid = 1'b1;
				if (byte_ready)
					next_state = usb_tx_cfg_pkg::S_CRC_HI;
			end
			usb_tx_cfg_pkg::S_CRC_HI: begin
				byte_sel = usb_tx_cfg_pkg::SEL_CRC_HI;
				byte_valid = 1'b1;
				if (byte_ready)
					next_state = usb_tx_cfg_pkg::S_EOP;
			end
			usb_tx_cfg_pkg::S_EOP: begin
				eop_req = 1'b1;
				next_state = usb_tx_cfg_pkg::S_EOP_WAIT;
			end
			usb_tx_cfg_pkg::S_EOP_WAIT: begin
				if (eop_done)
					next_state = usb_tx_cfg_pkg::S_IDLE;
			end
			default: next_state = usb_tx_cfg_pkg::S_IDLE;
		endcase
	end

	assign crc_enable = rd_en;

endmodule

`default_nettype wire

//--- rtl/usb_tx_encoder.sv
// USB line encoder
`timescale 1ns/1ps
`default_nettype none

module usb_tx_encoder (
	input wire logic clk,
	input wire logic n_rst,
	input wire usb_tx_cfg_pkg::byte_sel_t byte_sel,
	input wire usb_proto_pkg::pid_t pid,
	input wire logic [7:0] rd_data,
	input wire logic [15:0] crc,
	input wire logic byte_valid,
	output logic byte_ready,
	input wire logic eop_req,
	output logic eop_done,
	output logic dp,
	output logic dm
);

	logic [7:0] next_byte;
	logic [7:0] sreg;
	logic [3:0] bits_left;
	logic [2:0] ones_cnt;
	logic [usb_tx_cfg_pkg::DIV_W-1:0] div_cnt;
	logic active;
	logic eop_pend;
	// Steps 1 and 2 drive SE0 and step 3 the closing J
	logic [1:0] eop_step;
	logic bit_end;
	logic stuff_bit;

	always_comb begin
		case (byte_sel)
			usb_tx_cfg_pkg::SEL_SYNC: next_byte = usb_proto_pkg::SYNC_BYTE;
			usb_tx_cfg_pkg::SEL_PID: next_byte = {~pid, pid};
			usb_tx_cfg_pkg::SEL_DATA: next_byte = rd_data;
			usb_tx_cfg_pkg::SEL_CRC_LO: next_byte = crc[7:0];
			usb_tx_cfg_pkg::SEL_CRC_HI: next_byte = crc[15:8];
			default: next_byte = usb_proto_pkg::SYNC_BYTE;
		endcase
	end

	// Shifter empty while the last bit is still on the line
	assign byte_ready = (bits_left == 0) && !eop_pend && (eop_step == 0);

	// An idle line can start a bit on any clock
	assign bit_end = !active || (div_cnt == usb_tx_cfg_pkg::DIV_LAST);

	assign stuff_bit = active && (ones_cnt == 3'(usb_proto_pkg::STUFF_RUN));

	always_ff @(posedge clk) begin
		if (byte_valid && byte_ready)
			sreg <= next_byte;
		else if (bit_end && !stuff_bit && bits_left != 0 && eop_step == 0)
			sreg <= sreg >> 1;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			dp <= 1'b1;
			dm <= 1'b0;
			active <= 1'b0;
			div_cnt <= '0;
			bits_left <= '0;
			ones_cnt <= '0;
			eop_pend <= 1'b0;
			eop_step <= '0;
			eop_done <= 1'b0;
		end else begin
			eop_done <= 1'b0;
			div_cnt <= bit_end ? '0 : div_cnt + 1;
			if (eop_req)
				eop_pend <= 1'b1;
			if (byte_valid && byte_ready) begin
				bits_left <= 4'd8;
				if (byte_sel == usb_tx_cfg_pkg::SEL_SYNC)
					ones_cnt <= '0;
			end
			if (bit_end) begin
				if (eop_step == 2'd3) begin
					eop_step <= '0;
					active <= 1'b0;
					eop_done <= 1'b1;
				end else if (eop_step == 2'd2) begin
					dp <= 1'b1;
					dm <= 1'b0;
					eop_step <= 2'd3;
				end else if (eop_step == 2'd1) begin
					eop_step <= 2'd2;
				end else if (stuff_bit) begin
					// Stuffed zero holds the byte back one bit time
					dp <= ~dp;
					dm <= ~dm;
					ones_cnt <= '0;
				end else if (bits_left != 0) begin
					active <= 1'b1;
					bits_left <= bits_left - 1;
					if (sreg[0]) begin
						ones_cnt <= ones_cnt + 1;
					end else begin
						ones_cnt <= '0;
						dp <= ~dp;
						dm <= ~dm;
					end
				end else if (eop_pend) begin
					dp <= 1'b0;
					dm <= 1'b0;
					eop_step <= 2'd1;
					eop_pend <= 1'b0;
				end else begin
					active <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/usb_tx_crc16.sv
// Payload CRC16 generator
`timescale 1ns/1ps
`default_nettype none

module usb_tx_crc16 (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic crc_clear,
	input wire logic crc_enable,
	input wire logic [7:0] data,
	output logic [15:0] crc
);

	logic [15:0] crc_reg;
	logic [15:0] crc_next;

	// Whole byte per clock, LSB first
	always_comb begin
		crc_next = crc_reg;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0] ^ data[i])
				crc_next = (crc_next >> 1) ^ usb_proto_pkg::CRC16_POLY_REV;
			else
				crc_next = crc_next >> 1;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			crc_reg <= usb_proto_pkg::CRC16_INIT;
		else if (crc_clear)
			crc_reg <= usb_proto_pkg::CRC16_INIT;
		else if (crc_enable)
			crc_reg <= crc_next;
	end

	assign crc = ~crc_reg;

endmodule

`default_nettype wire

//--- rtl/usb_tx_fifo.sv
// Payload byte buffer
`timescale 1ns/1ps
`default_nettype none

module usb_tx_fifo (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic [7:0] in_data,
	input wire logic in_valid,
	output logic in_ready,
	input wire logic rd_en,
	output logic [7:0] rd_data,
	output logic [usb_tx_cfg_pkg::CNT_W-1:0] count
);

	logic [7:0] mem [usb_tx_cfg_pkg::FIFO_DEPTH];
	logic [usb_tx_cfg_pkg::PTR_W-1:0] wr_ptr;
	logic [usb_tx_cfg_pkg::PTR_W-1:0] rd_ptr;
	logic wr_en;

	// Depth is a power of two, so the top count bit means full
	assign in_ready = !count[usb_tx_cfg_pkg::CNT_W-1];
	assign wr_en = in_valid && in_ready;
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1;
				2'b01: count <= count - 1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/usb_tx_cfg_pkg.sv
// Transmitter configuration
`default_nettype none

package usb_tx_cfg_pkg;

	localparam int FIFO_DEPTH = 16;
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// Clocks per line bit
	localparam int BIT_DIV = 4;
	localparam int DIV_W = $clog2(BIT_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BIT_DIV - 1);

	typedef enum logic [3:0] {
		S_IDLE,
		S_SYNC,
		S_PID,
		S_DATA,
		S_CRC_WAIT,
		S_CRC_LO,
		S_CRC_HI,
		S_EOP,
		S_EOP_WAIT
	} tx_state_t;

	typedef enum logic [2:0] {
		SEL_SYNC,
		SEL_PID,
		SEL_DATA,
		SEL_CRC_LO,
		SEL_CRC_HI
	} byte_sel_t;

endpackage

`default_nettype wire

//--- rtl/usb_proto_pkg.sv
// USB protocol constants
`default_nettype none

package usb_proto_pkg;

	// Four-bit PID codes, complement is added on the wire
	typedef enum logic [3:0] {
		PID_DATA0 = 4'b0011,
		PID_DATA1 = 4'b1011,
		PID_ACK   = 4'b0010,
		PID_NAK   = 4'b1010,
		PID_STALL = 4'b1110
	} pid_t;

	// KJKJKJKK sent LSB first
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	// x^16 + x^15 + x^2 + 1, bit reversed
	localparam logic [15:0] CRC16_POLY_REV = 16'ha001;
	localparam logic [15:0] CRC16_INIT = 16'hffff;

	// Ones in a row before a stuffed zero
	localparam int STUFF_RUN = 6;

endpackage

`default_nettype wire
